// File: files.f
+incdir+dv
hdl/cheri_pkg.sv
hdl/cap_fields_if.sv
hdl/cap_field_decode.sv
hdl/cap_check.sv
hdl/cap_op_exec.sv
hdl/cheri_cap_alu.sv
dv/tb_cheri_cap_alu.sv

// File: dv/tb_cheri_vectors.svh
`ifndef TB_CHERI_VECTORS_SVH
`define TB_CHERI_VECTORS_SVH

// one operation together with the response it must produce
typedef struct {
  string                       name;
  cheri_pkg::cap_op_e          op;
  cheri_pkg::cap_t             a;
  cheri_pkg::cap_t             b;
  cheri_pkg::cap_t             exp_res;
  logic                        exp_wc;
  logic [cheri_pkg::EXC_W-1:0] exp_exc_a;
  logic [cheri_pkg::EXC_W-1:0] exp_exc_b;
} vec_t;

vec_t vecs[$];

// operands shared by the hand-written entries
cheri_pkg::cap_t c_obj;
cheri_pkg::cap_t c_sealed;
cheri_pkg::cap_t c_untag;
cheri_pkg::cap_t c_root;

// field order follows the struct: tag, perms, otype, base, length, addr
function automatic cheri_pkg::cap_t mk_cap(input logic tag, input logic [11:0] perms,
    input logic [3:0] otype, input logic [31:0] base, input logic [32:0] length,
    input logic [31:0] addr);
  return {tag, perms, otype, base, length, addr};
endfunction

// an integer travels as a null capability with the value in addr
function automatic cheri_pkg::cap_t i_cap(input logic [31:0] value);
  return mk_cap(1'b0, 12'h0, 4'h0, 32'h0, 33'h0, value);
endfunction

task automatic add_vec(input string name, input cheri_pkg::cap_op_e op,
    input cheri_pkg::cap_t a, input cheri_pkg::cap_t b, input cheri_pkg::cap_t res,
    input logic wc, input logic [5:0] exc_a, input logic [5:0] exc_b);
  vec_t v;
  v = '{name, op, a, b, res, wc, exc_a, exc_b};
  vecs.push_back(v);
endtask

task automatic build_vectors();
  // region 0x2000 to 0x2100 with the cursor at offset 0x40
  c_obj    = mk_cap(1'b1, 12'h3c3, 4'hf, 32'h2000, 33'h100, 32'h2040);
  c_sealed = mk_cap(1'b1, 12'h3c3, 4'h5, 32'h2000, 33'h100, 32'h2040);
  c_untag  = mk_cap(1'b0, 12'h3c3, 4'hf, 32'h2000, 33'h100, 32'h2040);
  c_root   = mk_cap(1'b1, 12'hfff, 4'hf, 32'h0, 33'h1_0000_0000, 32'h1000);
  add_vec("getperm", cheri_pkg::CGETPERM, c_obj, i_cap(0), i_cap(32'h3c3), 0, 0, 0);
  add_vec("gettype_unsealed", cheri_pkg::CGETTYPE, c_obj, i_cap(0), i_cap('1), 0, 0, 0);
  add_vec("gettype_sealed", cheri_pkg::CGETTYPE, c_sealed, i_cap(0), i_cap(5), 0, 0, 0);
  add_vec("getbase", cheri_pkg::CGETBASE, c_obj, i_cap(0), i_cap(32'h2000), 0, 0, 0);
  add_vec("getlen_full", cheri_pkg::CGETLEN, c_root, i_cap(0), i_cap('1), 0, 0, 0);
  add_vec("getlen", cheri_pkg::CGETLEN, c_obj, i_cap(0), i_cap(32'h100), 0, 0, 0);
  add_vec("gettag", cheri_pkg::CGETTAG, c_untag, i_cap(0), i_cap(0), 0, 0, 0);
  add_vec("gettag_set", cheri_pkg::CGETTAG, c_obj, i_cap(0), i_cap(1), 0, 0, 0);
  add_vec("getsealed", cheri_pkg::CGETSEALED, c_sealed, i_cap(0), i_cap(1), 0, 0, 0);
  add_vec("getoffset", cheri_pkg::CGETOFFSET, c_obj, i_cap(0), i_cap(32'h40), 0, 0, 0);
  add_vec("getaddr", cheri_pkg::CGETADDR, c_obj, i_cap(0), i_cap(32'h2040), 0, 0, 0);
  add_vec("move", cheri_pkg::CMOVE, c_obj, i_cap(0), c_obj, 1, 0, 0);
  add_vec("cleartag", cheri_pkg::CCLEARTAG, c_obj, i_cap(0), c_untag, 1, 0, 0);
  add_vec("andperm", cheri_pkg::CANDPERM, c_obj, i_cap(32'h0f0),
          mk_cap(1'b1, 12'h0c0, 4'hf, 32'h2000, 33'h100, 32'h2040), 1, 0, 0);
  add_vec("setbounds", cheri_pkg::CSETBOUNDS, c_obj, i_cap(32'h20),
          mk_cap(1'b1, 12'h3c3, 4'hf, 32'h2040, 33'h20, 32'h2040), 1, 0, 0);
  // 0x2040 plus 0x100 runs past the top at 0x2100
  add_vec("setbounds_overrun", cheri_pkg::CSETBOUNDS, c_obj, i_cap(32'h100),
          mk_cap(1'b1, 12'h3c3, 4'hf, 32'h2040, 33'h100, 32'h2040), 1, 6'h08, 0);
  add_vec("setbounds_untagged", cheri_pkg::CSETBOUNDS, c_untag, i_cap(32'h20),
          mk_cap(1'b0, 12'h3c3, 4'hf, 32'h2040, 33'h20, 32'h2040), 1, 6'h01, 0);
  add_vec("setoffset", cheri_pkg::CSETOFFSET, c_obj, i_cap(32'h10),
          mk_cap(1'b1, 12'h3c3, 4'hf, 32'h2000, 33'h100, 32'h2010), 1, 0, 0);
  add_vec("incoffset", cheri_pkg::CINCOFFSET, c_obj, i_cap(32'h8),
          mk_cap(1'b1, 12'h3c3, 4'hf, 32'h2000, 33'h100, 32'h2048), 1, 0, 0);
  add_vec("setaddr_sealed", cheri_pkg::CSETADDR, c_sealed, i_cap(32'h2080),
          mk_cap(1'b1, 12'h3c3, 4'h5, 32'h2000, 33'h100, 32'h2080), 1, 6'h02, 0);
  // the sealing authority covers types 0 to 15 and holds both seal permissions
  add_vec("seal", cheri_pkg::CSEAL, c_obj,
          mk_cap(1'b1, 12'h280, 4'hf, 32'h0, 33'h10, 32'h5), c_sealed, 1, 0, 0);
  add_vec("seal_no_permit", cheri_pkg::CSEAL, c_obj,
          mk_cap(1'b1, 12'h200, 4'hf, 32'h0, 33'h10, 32'h5), c_sealed, 1, 0, 6'h10);
  add_vec("seal_reserved_type", cheri_pkg::CSEAL, c_obj,
          mk_cap(1'b1, 12'h280, 4'hf, 32'h0, 33'h10, 32'hf), c_obj, 1, 0, 6'h08);
  add_vec("unseal", cheri_pkg::CUNSEAL, c_sealed,
          mk_cap(1'b1, 12'h280, 4'hf, 32'h0, 33'h10, 32'h5), c_obj, 1, 0, 0);
  add_vec("unseal_wrong_type", cheri_pkg::CUNSEAL, c_sealed,
          mk_cap(1'b1, 12'h280, 4'hf, 32'h0, 33'h10, 32'h6), c_obj, 1, 0, 6'h04);
  add_vec("sub", cheri_pkg::CSUB, c_obj, i_cap(32'h40), i_cap(32'h2000), 0, 0, 0);
endtask

`endif

// File: dv/tb_cheri_cap_alu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_cheri_cap_alu;

  logic                        clk_i;
  logic                        rst_n_i;
  logic                        valid_i;
  cheri_pkg::cap_op_e          op_i;
  cheri_pkg::cap_t             operand_a_i;
  cheri_pkg::cap_t             operand_b_i;
  logic                        valid_o;
  cheri_pkg::cap_t             result_o;
  logic                        wrote_cap_o;
  logic [cheri_pkg::EXC_W-1:0] exc_a_o;
  logic [cheri_pkg::EXC_W-1:0] exc_b_o;

  int          errors;
  int          checked;
  int          cycles;
  int          timeout_limit;
  logic [31:0] lfsr;
  // valid_i as seen by the last rising edge
  logic        issued_q;

  `include "tb_cheri_vectors.svh"

  cheri_cap_alu u_dut (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .operand_a_i (operand_a_i),
    .operand_b_i (operand_b_i),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .wrote_cap_o (wrote_cap_o),
    .exc_a_o     (exc_a_o),
    .exc_b_o     (exc_b_o)
  );

  always #20 clk_i = ~clk_i;

  // Galois form of x^32 + x^22 + x^2 + x + 1, shifting right
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one LFSR step per bit taken
  task automatic take_bits(input int n, output logic [31:0] w);
    w = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      w = {w[30:0], lfsr[0]};
    end
  endtask

  task automatic compare_field(input string name, input string what,
      input logic [113:0] exp, input logic [113:0] act);
    assert (act === exp) else begin
      errors++;
      $display("Mismatch %s %s expected %0h actual %0h", name, what, exp, act);
    end
  endtask

  task automatic check_result(input vec_t v);
    compare_field(v.name, "result", v.exp_res, result_o);
    compare_field(v.name, "wrote_cap", v.exp_wc, wrote_cap_o);
    compare_field(v.name, "exc_a", v.exp_exc_a, exc_a_o);
    compare_field(v.name, "exc_b", v.exp_exc_b, exc_b_o);
  endtask

  // the result of an issued operation must appear on the very next rising edge
  always @(posedge clk_i) begin
    issued_q <= valid_i;
  end

  // outputs move on the rising edge, so they are read on the falling edge
  // results come back in issue order, one per operation
  always @(negedge clk_i) begin
    if (rst_n_i) begin
      assert (valid_o === issued_q) else begin
        errors++;
        $display("valid_o is %b one cycle after valid_i was %b", valid_o, issued_q);
      end
    end
    if (rst_n_i && valid_o) begin
      assert (checked < vecs.size()) else begin
        errors++;
        $display("valid_o went high with no operation outstanding");
      end
      if (checked < vecs.size()) begin
        check_result(vecs[checked]);
      end
      checked++;
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles >= timeout_limit) begin
      $display("timeout after %0d cycles, the run did not complete", cycles);
      $display("RESULT: FAIL");
      $finish;
    end
  end

  initial begin
    cheri_pkg::cap_t a;
    cheri_pkg::cap_t exp;
    logic [31:0]     ra;
    logic [31:0]     rb;
    clk_i       = 1'b0;
    rst_n_i     = 1'b0;
    valid_i     = 1'b0;
    op_i        = cheri_pkg::CGETPERM;
    operand_a_i = '0;
    operand_b_i = '0;
    issued_q    = 1'b0;
    errors      = 0;
    checked     = 0;
    cycles      = 0;
    lfsr        = 32'h2550_581a;
    build_vectors();
    // random cursors on the plain region, alternating add and subtract
    for (int i = 0; i < 16; i++) begin
      take_bits(32, ra);
      take_bits(32, rb);
      a = c_obj;
      a.addr = ra;
      exp = a;
      exp.addr = ra + rb;
      if (i % 2 == 0) begin
        add_vec($sformatf("rand_incoffset_%0d", i), cheri_pkg::CINCOFFSET, a, i_cap(rb),
                exp, 1, 0, 0);
      end else begin
        add_vec($sformatf("rand_sub_%0d", i), cheri_pkg::CSUB, a, i_cap(rb),
                i_cap(ra - rb), 0, 0, 0);
      end
    end
    timeout_limit = vecs.size() + 3 + 20;

    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    assert (valid_o === 1'b0 && wrote_cap_o === 1'b0 && result_o === '0 &&
            exc_a_o === '0 && exc_b_o === '0) else begin
      errors++;
      $display("outputs were not idle after reset");
    end

    // back to back issue, one entry per cycle
    foreach (vecs[i]) begin
      op_i        = vecs[i].op;
      operand_a_i = vecs[i].a;
      operand_b_i = vecs[i].b;
      valid_i     = 1'b1;
      @(negedge clk_i);
    end
    valid_i = 1'b0;
    repeat (2) @(negedge clk_i);

    assert (checked == vecs.size()) else begin
      errors++;
      $display("only %0d of %0d results came back", checked, vecs.size());
    end
    $display("checked %0d of %0d results, errors %0d", checked, vecs.size(), errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: hdl/cheri_cap_alu.sv
`timescale 1ns/1ns
`default_nettype none

// capability ALU top level
// two field decoders and the flag checker are combinational
// so the executor registers the result one cycle after valid_i
module cheri_cap_alu #(
  parameter int unsigned PERMIT_SEAL_IDX   = cheri_pkg::PERMIT_SEAL_BIT,
  parameter int unsigned PERMIT_UNSEAL_IDX = cheri_pkg::PERMIT_UNSEAL_BIT
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        valid_i,
  input  cheri_pkg::cap_op_e          op_i,
  input  cheri_pkg::cap_t             operand_a_i,
  input  cheri_pkg::cap_t             operand_b_i,
  output logic                        valid_o,
  output cheri_pkg::cap_t             result_o,
  output logic                        wrote_cap_o,
  output logic [cheri_pkg::EXC_W-1:0] exc_a_o,
  output logic [cheri_pkg::EXC_W-1:0] exc_b_o
);

  // per operand violation flags from the checker
  logic [cheri_pkg::EXC_W-1:0] flags_a;
  logic [cheri_pkg::EXC_W-1:0] flags_b;

  // decoded operand fields
  cap_fields_if fa_if ();
  cap_fields_if fb_if ();

  cap_field_decode u_decode_a (
    .cap_i  (operand_a_i),
    .fields (fa_if)
  );

  cap_field_decode u_decode_b (
    .cap_i  (operand_b_i),
    .fields (fb_if)
  );

  cap_check #(
    .PERMIT_SEAL_IDX   (PERMIT_SEAL_IDX),
    .PERMIT_UNSEAL_IDX (PERMIT_UNSEAL_IDX)
  ) u_check (
    .fa        (fa_if),
    .fb        (fb_if),
    .flags_a_o (flags_a),
    .flags_b_o (flags_b)
  );

  // the raw operands go along because the modifiers copy the untouched fields
  cap_op_exec u_exec (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .valid_i     (valid_i),
    .op_i        (op_i),
    .cap_a_i     (operand_a_i),
    .cap_b_i     (operand_b_i),
    .fa          (fa_if),
    .fb          (fb_if),
    .flags_a_i   (flags_a),
    .flags_b_i   (flags_b),
    .valid_o     (valid_o),
    .result_o    (result_o),
    .wrote_cap_o (wrote_cap_o),
    .exc_a_o     (exc_a_o),
    .exc_b_o     (exc_b_o)
  );

endmodule

`default_nettype wire

// File: hdl/cap_op_exec.sv
`timescale 1ns/1ns
`default_nettype none

// opcode case of the capability ALU followed by the single output register stage
module cap_op_exec (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  logic                        valid_i,
  input  cheri_pkg::cap_op_e          op_i,
  input  cheri_pkg::cap_t             cap_a_i,
  input  cheri_pkg::cap_t             cap_b_i,
  cap_fields_if.sink                  fa,
  cap_fields_if.sink                  fb,
  input  logic [cheri_pkg::EXC_W-1:0] flags_a_i,
  input  logic [cheri_pkg::EXC_W-1:0] flags_b_i,
  output logic                        valid_o,
  output cheri_pkg::cap_t             result_o,
  output logic                        wrote_cap_o,
  output logic [cheri_pkg::EXC_W-1:0] exc_a_o,
  output logic [cheri_pkg::EXC_W-1:0] exc_b_o
);

  cheri_pkg::cap_t             result_d;
  logic                        wrote_cap_d;
  logic [cheri_pkg::EXC_W-1:0] exc_a_d;
  logic [cheri_pkg::EXC_W-1:0] exc_b_d;
  logic                        op_known;

  // end of the new region asked for by CSETBOUNDS, with the carry kept
  logic [cheri_pkg::LEN_W-1:0] bounds_end;
  // operand b's address widened for compares against a top value
  logic [cheri_pkg::LEN_W-1:0] b_addr_ext;
  // operand a's otype widened for the compare against b's address
  logic [cheri_pkg::XLEN-1:0]  a_otype_ext;

  assign bounds_end  = {1'b0, fa.addr} + {1'b0, fb.addr};
  assign b_addr_ext  = {1'b0, cap_b_i.addr};
  assign a_otype_ext = {{(cheri_pkg::XLEN-cheri_pkg::OTYPE_W){1'b0}}, fa.otype};

  // integers leave the ALU as a null capability carrying the value in addr
  function automatic cheri_pkg::cap_t int_result(input logic [cheri_pkg::XLEN-1:0] value);
    cheri_pkg::cap_t res;
    res = '0;
    res.addr = value;
    return res;
  endfunction

  always_comb begin
    result_d    = '0;
    wrote_cap_d = 1'b0;
    exc_a_d     = '0;
    exc_b_d     = '0;
    op_known    = 1'b1;

    case (op_i)
      cheri_pkg::CGETPERM: begin
        result_d = int_result({{(cheri_pkg::XLEN-cheri_pkg::PERMS_W){1'b0}}, fa.perms});
      end
      cheri_pkg::CGETTYPE: begin
        // unsealed capabilities report -1 rather than the reserved type
        result_d = int_result(fa.sealed ? a_otype_ext : {cheri_pkg::XLEN{1'b1}});
      end
      cheri_pkg::CGETBASE: begin
        result_d = int_result(fa.base);
      end
      cheri_pkg::CGETLEN: begin
        // a length of 2**32 does not fit the register, so it saturates
        result_d = int_result(cap_a_i.length[cheri_pkg::LEN_W-1] ? {cheri_pkg::XLEN{1'b1}}
                                                                 : cap_a_i.length[cheri_pkg::XLEN-1:0]);
      end
      cheri_pkg::CGETTAG: begin
        result_d = int_result({{(cheri_pkg::XLEN-1){1'b0}}, fa.tag});
      end
      cheri_pkg::CGETSEALED: begin
        result_d = int_result({{(cheri_pkg::XLEN-1){1'b0}}, fa.sealed});
      end
      cheri_pkg::CGETOFFSET: begin
        result_d = int_result(fa.offset);
      end
      cheri_pkg::CGETADDR: begin
        result_d = int_result(fa.addr);
      end
      cheri_pkg::CMOVE: begin
        result_d    = cap_a_i;
        wrote_cap_d = 1'b1;
      end
      cheri_pkg::CCLEARTAG: begin
        result_d     = cap_a_i;
        result_d.tag = 1'b0;
        wrote_cap_d  = 1'b1;
      end
      cheri_pkg::CANDPERM: begin
        // permissions can only ever be removed
        result_d       = cap_a_i;
        result_d.perms = cap_a_i.perms & fb.addr[cheri_pkg::PERMS_W-1:0];
        wrote_cap_d    = 1'b1;
        exc_a_d[cheri_pkg::EXC_TAG]  = flags_a_i[cheri_pkg::EXC_TAG];
        exc_a_d[cheri_pkg::EXC_SEAL] = flags_a_i[cheri_pkg::EXC_SEAL];
      end
      cheri_pkg::CSETBOUNDS: begin
        // the new region starts at the cursor and must stay inside the old one
        result_d        = cap_a_i;
        result_d.base   = cap_a_i.addr;
        result_d.length = b_addr_ext;
        wrote_cap_d     = 1'b1;
        exc_a_d[cheri_pkg::EXC_TAG]    = flags_a_i[cheri_pkg::EXC_TAG];
        exc_a_d[cheri_pkg::EXC_SEAL]   = flags_a_i[cheri_pkg::EXC_SEAL];
        exc_a_d[cheri_pkg::EXC_LENGTH] = flags_a_i[cheri_pkg::EXC_LENGTH] ||
                                         (bounds_end > fa.top);
      end
      cheri_pkg::CSETOFFSET: begin
        // offsets are always representable here, so the result stays a capability
        result_d      = cap_a_i;
        result_d.addr = fa.base + fb.addr;
        wrote_cap_d   = 1'b1;
        exc_a_d[cheri_pkg::EXC_SEAL] = flags_a_i[cheri_pkg::EXC_SEAL];
      end
      cheri_pkg::CINCOFFSET: begin
        result_d      = cap_a_i;
        result_d.addr = fa.addr + fb.addr;
        wrote_cap_d   = 1'b1;
        exc_a_d[cheri_pkg::EXC_SEAL] = flags_a_i[cheri_pkg::EXC_SEAL];
      end
      cheri_pkg::CSETADDR: begin
        result_d      = cap_a_i;
        result_d.addr = fb.addr;
        wrote_cap_d   = 1'b1;
        exc_a_d[cheri_pkg::EXC_SEAL] = flags_a_i[cheri_pkg::EXC_SEAL];
      end
      cheri_pkg::CSEAL: begin
        // b is the sealing authority and its cursor selects the object type
        result_d       = cap_a_i;
        result_d.otype = fb.addr[cheri_pkg::OTYPE_W-1:0];
        wrote_cap_d    = 1'b1;
        exc_a_d[cheri_pkg::EXC_TAG]  = flags_a_i[cheri_pkg::EXC_TAG];
        exc_a_d[cheri_pkg::EXC_SEAL] = flags_a_i[cheri_pkg::EXC_SEAL];
        exc_b_d[cheri_pkg::EXC_TAG]         = flags_b_i[cheri_pkg::EXC_TAG];
        exc_b_d[cheri_pkg::EXC_SEAL]        = flags_b_i[cheri_pkg::EXC_SEAL];
        exc_b_d[cheri_pkg::EXC_PERMIT_SEAL] = flags_b_i[cheri_pkg::EXC_PERMIT_SEAL];
        // the reserved unsealed type may not be handed out
        exc_b_d[cheri_pkg::EXC_LENGTH] = flags_b_i[cheri_pkg::EXC_LENGTH] ||
            (b_addr_ext >= fb.top) ||
            (fb.addr >= {{(cheri_pkg::XLEN-cheri_pkg::OTYPE_W){1'b0}}, cheri_pkg::OTYPE_UNSEALED});
      end
      cheri_pkg::CUNSEAL: begin
        result_d       = cap_a_i;
        result_d.otype = cheri_pkg::OTYPE_UNSEALED;
        wrote_cap_d    = 1'b1;
        // here a must be sealed, which turns the usual seal check around
        exc_a_d[cheri_pkg::EXC_TAG]  = flags_a_i[cheri_pkg::EXC_TAG];
        exc_a_d[cheri_pkg::EXC_SEAL] = !fa.sealed;
        exc_b_d[cheri_pkg::EXC_TAG]           = flags_b_i[cheri_pkg::EXC_TAG];
        exc_b_d[cheri_pkg::EXC_SEAL]          = fb.sealed;
        exc_b_d[cheri_pkg::EXC_TYPE]          = (fb.addr != a_otype_ext);
        exc_b_d[cheri_pkg::EXC_PERMIT_UNSEAL] = flags_b_i[cheri_pkg::EXC_PERMIT_UNSEAL];
        exc_b_d[cheri_pkg::EXC_LENGTH]        = (b_addr_ext >= fb.top);
      end
      cheri_pkg::CSUB: begin
        result_d = int_result(fa.addr - fb.addr);
      end
      default: begin
        op_known = 1'b0;
      end
    endcase
  end

  // data registers only load on an issued operation
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o     <= 1'b0;
      result_o    <= '0;
      wrote_cap_o <= 1'b0;
      exc_a_o     <= '0;
      exc_b_o     <= '0;
    end else begin
      valid_o <= valid_i && op_known;
      if (valid_i) begin
        result_o    <= result_d;
        wrote_cap_o <= wrote_cap_d;
        exc_a_o     <= exc_a_d;
        exc_b_o     <= exc_b_d;
      end
    end
  end

  // the register stage comes out of reset empty
  a_no_valid_after_reset: assert property (@(posedge clk_i) !rst_n_i |=> !valid_o)
    else $error("valid_o high on the cycle after reset");

  // an opcode code past the last enum value is dropped
  a_unknown_op_dropped: assert property (@(posedge clk_i) disable iff (!rst_n_i)
                                         (valid_i && (op_i > cheri_pkg::CSUB)) |=> !valid_o)
    else $error("unknown opcode produced a valid result");

endmodule

`default_nettype wire

// File: hdl/cap_check.sv
`timescale 1ns/1ns
`default_nettype none

// common violation flags for both operands
// each opcode in the executor picks the subset of flags that applies to it
module cap_check #(
  parameter int unsigned PERMIT_SEAL_IDX   = cheri_pkg::PERMIT_SEAL_BIT,
  parameter int unsigned PERMIT_UNSEAL_IDX = cheri_pkg::PERMIT_UNSEAL_BIT
) (
  cap_fields_if.sink                  fa,
  cap_fields_if.sink                  fb,
  output logic [cheri_pkg::EXC_W-1:0] flags_a_o,
  output logic [cheri_pkg::EXC_W-1:0] flags_b_o
);

  // the same rule set is applied to each operand
  function automatic logic [cheri_pkg::EXC_W-1:0] operand_flags(
    input logic                          tag,
    input logic                          sealed,
    input logic [cheri_pkg::XLEN-1:0]    addr,
    input logic [cheri_pkg::XLEN-1:0]    base,
    input logic [cheri_pkg::PERMS_W-1:0] perms
  );
    logic [cheri_pkg::EXC_W-1:0] flags;
    flags = '0;
    // an untagged value can never be used as a capability
    flags[cheri_pkg::EXC_TAG] = !tag;
    // the seal violation is only raised on a valid capability
    // so an untagged operand reports just the tag problem
    flags[cheri_pkg::EXC_SEAL] = tag && sealed;
    // the cursor sits below the region
    flags[cheri_pkg::EXC_LENGTH] = (addr < base);
    // the type flag depends on both operands and on the opcode, so the executor builds it
    flags[cheri_pkg::EXC_TYPE] = 1'b0;
    flags[cheri_pkg::EXC_PERMIT_SEAL] = !perms[PERMIT_SEAL_IDX];
    flags[cheri_pkg::EXC_PERMIT_UNSEAL] = !perms[PERMIT_UNSEAL_IDX];
    return flags;
  endfunction

  always_comb begin
    flags_a_o = operand_flags(fa.tag, fa.sealed, fa.addr, fa.base, fa.perms);
    flags_b_o = operand_flags(fb.tag, fb.sealed, fb.addr, fb.base, fb.perms);
  end

endmodule

`default_nettype wire

// File: hdl/cap_field_decode.sv
`timescale 1ns/1ns
`default_nettype none

// turns one raw capability into the field bundle used by the rest of the ALU
// the format is uncompressed, so most fields are plain wires
// only top, offset and the sealed state cost logic
module cap_field_decode (
  input  cheri_pkg::cap_t     cap_i,
  cap_fields_if.source        fields
);

  // zero extended base so that the top adder works on LEN_W bits
  logic [cheri_pkg::LEN_W-1:0] base_ext;

  assign base_ext = {1'b0, cap_i.base};

  // fields that are read straight from the struct
  assign fields.tag   = cap_i.tag;
  assign fields.perms = cap_i.perms;
  assign fields.otype = cap_i.otype;
  assign fields.base  = cap_i.base;
  assign fields.addr  = cap_i.addr;

  // top is the first address past the end of the region
  // a full-space capability has base 0 and length 2**32, which gives top bit 32 set
  assign fields.top = base_ext + cap_i.length;

  // the offset wraps like any other address arithmetic
  // an address below base shows up as a large offset, the checker flags it separately
  assign fields.offset = cap_i.addr - cap_i.base;

  // any object type other than the reserved one marks a sealed capability
  assign fields.sealed = (cap_i.otype != cheri_pkg::OTYPE_UNSEALED);

endmodule

`default_nettype wire

// File: hdl/cap_fields_if.sv
`timescale 1ns/1ns
`default_nettype none

// one operand after decode
// the raw fields are passed on next to the values derived from them
interface cap_fields_if;

  logic                         tag;
  logic                         sealed;
  logic [cheri_pkg::PERMS_W-1:0] perms;
  logic [cheri_pkg::OTYPE_W-1:0] otype;
  logic [cheri_pkg::XLEN-1:0]    base;
  // top needs the extra bit of the length field
  logic [cheri_pkg::LEN_W-1:0]   top;
  logic [cheri_pkg::XLEN-1:0]    addr;
  logic [cheri_pkg::XLEN-1:0]    offset;

  // the decoder owns every signal of the bundle
  modport source (
    output tag, sealed, perms, otype, base, top, addr, offset
  );

  // the checker and the executor only look at the fields
  modport sink (
    input tag, sealed, perms, otype, base, top, addr, offset
  );

endinterface

`default_nettype wire

// File: hdl/cheri_pkg.sv
`default_nettype none

package cheri_pkg;

  // integer registers and addresses are 32 bits wide on this core
  parameter int unsigned XLEN = 32;

  // length and top carry one extra bit so that a capability can span the whole address space
  parameter int unsigned LEN_W = 33;

  // permission field width of the uncompressed format
  parameter int unsigned PERMS_W = 12;

  // object types are kept small since sealing is only used by a handful of compartments
  parameter int unsigned OTYPE_W = 4;

  // the all ones object type is reserved and means the capability is not sealed
  parameter logic [OTYPE_W-1:0] OTYPE_UNSEALED = {OTYPE_W{1'b1}};

  // positions of the sealing permissions inside the perms field
  parameter int unsigned PERMIT_SEAL_BIT = 7;
  parameter int unsigned PERMIT_UNSEAL_BIT = 9;

  // one exception vector per operand, indexed by cap_exc_e
  parameter int unsigned EXC_W = 6;

  // uncompressed capability
  // every field is stored as it is, so no decompression logic is needed to read it
  // the struct is 1 + 12 + 4 + 32 + 33 + 32 = 114 bits wide
  typedef struct packed {
    logic               tag;
    logic [PERMS_W-1:0] perms;
    logic [OTYPE_W-1:0] otype;
    logic [XLEN-1:0]    base;
    logic [LEN_W-1:0]   length;
    logic [XLEN-1:0]    addr;
  } cap_t;

  // flat opcode space of the capability ALU
  // the field readers come first, then the modifiers, sealing and subtract
  typedef enum logic [4:0] {
    CGETPERM   = 5'd0,
    CGETTYPE   = 5'd1,
    CGETBASE   = 5'd2,
    CGETLEN    = 5'd3,
    CGETTAG    = 5'd4,
    CGETSEALED = 5'd5,
    CGETOFFSET = 5'd6,
    CGETADDR   = 5'd7,
    CMOVE      = 5'd8,
    CCLEARTAG  = 5'd9,
    CANDPERM   = 5'd10,
    CSETBOUNDS = 5'd11,
    CSETOFFSET = 5'd12,
    CINCOFFSET = 5'd13,
    CSETADDR   = 5'd14,
    CSEAL      = 5'd15,
    CUNSEAL    = 5'd16,
    CSUB       = 5'd17
  } cap_op_e;

  // bit positions inside an exception vector
  typedef enum logic [2:0] {
    EXC_TAG           = 3'd0,
    EXC_SEAL          = 3'd1,
    EXC_TYPE          = 3'd2,
    EXC_LENGTH        = 3'd3,
    EXC_PERMIT_SEAL   = 3'd4,
    EXC_PERMIT_UNSEAL = 3'd5
  } cap_exc_e;

endpackage

`default_nettype wire
